//--- Bender.yml
package:
  name: dsp_block

sources:
  - design/dsp_block_pkg.sv
  - design/block_config.sv
  - design/channel_store.sv
  - design/sat_adder.sv
  - design/frac_multiplier.sv
  - design/block_sequencer.sv
  - design/dsp_block.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/dsp_block_tb.sv

//--- design/block_config.sv
module block_config import dsp_block_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  logic          instr_write,
	input  block_instr_t  instr_val,
	input  reg_write_t    reg_wr,
	input  result_write_t result,
	input  operand_sel_t  sel_a,
	input  operand_sel_t  sel_b,
	input  operand_sel_t  sel_c,
	output block_instr_t  instr,
	output sample_t       reg_a,
	output sample_t       reg_b,
	output sample_t       reg_c
);

	// Coefficient file
	sample_t coef [n_registers];

	// Write-back lands here only for register destinations
	logic result_hit;

	assign result_hit = result.en && result.dest.is_reg;

	// Instruction register, NOP after reset
	always_ff @(posedge clk) begin
		if (reset) begin
			instr <= '0;
		end else if (instr_write) begin
			instr <= instr_val;
		end
	end

	// Host write and write-back may hit the same cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < n_registers; i++) begin
				coef[i] <= '0;
			end
		end else begin
			for (int i = 0; i < n_registers; i++) begin
				// Host wins when both target the same entry
				if (reg_wr.en && reg_wr.target == addr_width'(i)) begin
					coef[i] <= reg_wr.value;
				end else if (result_hit && result.dest.addr == addr_width'(i)) begin
					coef[i] <= result.value;
				end
			end
		end
	end

	// Combinational read ports, one per source operand
	assign reg_a = coef[sel_a.addr];
	assign reg_b = coef[sel_b.addr];
	assign reg_c = coef[sel_c.addr];

endmodule

//--- design/block_sequencer.sv
module block_sequencer import dsp_block_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  logic          tick,
	input  block_instr_t  instr,
	input  sample_t       reg_a,
	input  sample_t       reg_b,
	input  sample_t       reg_c,
	input  sample_t       ch_a,
	input  sample_t       ch_b,
	input  sample_t       ch_c,
	input  sample_t       sum,
	input  sample_t       product,
	input  logic          product_valid,
	output operand_sel_t  sel_a,
	output operand_sel_t  sel_b,
	output operand_sel_t  sel_c,
	output sample_t       adder_a,
	output sample_t       adder_b,
	output logic          adder_subtract,
	output logic          saturate,
	output mul_req_t      mul_req,
	output result_write_t result,
	output logic          done
);

	typedef enum logic [2:0] {
		st_idle,
		st_fetch,
		st_exec,
		st_mul_wait,
		st_add_write
	} seq_state_e;

	seq_state_e   state;
	block_instr_t cur_instr;

	// Latched operands
	sample_t op_a;
	sample_t op_b;
	sample_t op_c;

	sample_t unary_value;
	logic    is_unary;

	// Selects follow the live instruction, only the fetch cycle uses them
	assign sel_a = '{is_reg: instr.src_a_reg, addr: instr.src_a};
	assign sel_b = '{is_reg: instr.src_b_reg, addr: instr.src_b};
	assign sel_c = '{is_reg: instr.src_c_reg, addr: instr.src_c};

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= st_idle;
			done      <= 1'b1;
			cur_instr <= '0;
		end else if (tick) begin
			// Channels load on this edge, so fetch follows
			state <= st_fetch;
			done  <= 1'b0;
		end else begin
			case (state)
				st_fetch: begin
					// Freeze the instruction for the rest of the tick
					cur_instr <= instr;
					state     <= st_exec;
				end
				st_exec: begin
					case (cur_instr.op)
						op_add, op_sub: state <= st_add_write;
						op_mul, op_mac: state <= st_mul_wait;
						default: begin
							// NOP and the single-operand ops finish here
							state <= st_idle;
							done  <= 1'b1;
						end
					endcase
				end
				st_mul_wait: begin
					if (product_valid) begin
						if (cur_instr.op == op_mac) begin
							state <= st_add_write;
						end else begin
							state <= st_idle;
							done  <= 1'b1;
						end
					end
				end
				st_add_write: begin
					state <= st_idle;
					done  <= 1'b1;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Each store returns a value, is_reg picks the source
	always_ff @(posedge clk) begin
		if (state == st_fetch) begin
			op_a <= sel_a.is_reg ? reg_a : ch_a;
			op_b <= sel_b.is_reg ? reg_b : ch_b;
			op_c <= sel_c.is_reg ? reg_c : ch_c;
		end
	end

	// LSH wraps, RSH keeps the sign, ABS of -32768 wraps onto itself
	always_comb begin
		case (cur_instr.op)
			op_lsh: unary_value = op_a <<< 1;
			op_rsh: unary_value = op_a >>> 1;
			op_abs: unary_value = op_a[data_width-1] ? -op_a : op_a;
			default: unary_value = op_a;
		endcase
	end

	assign is_unary = cur_instr.op inside {op_lsh, op_rsh, op_abs};
	assign saturate = !cur_instr.no_sat;

	// MAC feeds the product and c into the adder once the product lands
	always_comb begin
		if (state == st_mul_wait) begin
			adder_a        = product;
			adder_b        = op_c;
			adder_subtract = 1'b0;
		end else begin
			adder_a        = op_a;
			adder_b        = op_b;
			adder_subtract = cur_instr.op == op_sub;
		end
	end

	// One request per tick
	assign mul_req.valid    = state == st_exec && cur_instr.op inside {op_mul, op_mac};
	assign mul_req.a        = op_a;
	assign mul_req.b        = op_b;
	assign mul_req.shift    = cur_instr.shift;
	assign mul_req.saturate = saturate;

	always_comb begin
		result.dest = '{is_reg: cur_instr.dest_reg, addr: cur_instr.dest};
		case (state)
			st_exec: begin
				result.en    = is_unary;
				result.value = unary_value;
			end
			st_mul_wait: begin
				result.en    = product_valid && cur_instr.op == op_mul;
				result.value = product;
			end
			st_add_write: begin
				result.en    = 1'b1;
				result.value = sum;
			end
			default: begin
				result.en    = 1'b0;
				result.value = sum;
			end
		endcase
		// A restarting tick drops any write-back in flight
		if (tick) begin
			result.en = 1'b0;
		end
	end

endmodule

//--- design/channel_store.sv
module channel_store import dsp_block_pkg::*; (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             tick,
	input  logic [n_channels*data_width-1:0] ch_in,
	input  result_write_t                    result,
	input  operand_sel_t                     sel_a,
	input  operand_sel_t                     sel_b,
	input  operand_sel_t                     sel_c,
	output logic [n_channels*data_width-1:0] ch_out,
	output sample_t                          ch_a,
	output sample_t                          ch_b,
	output sample_t                          ch_c
);

	sample_t ch_regs [n_channels];

	// Only channel destinations belong to this store
	logic result_hit;

	assign result_hit = result.en && !result.dest.is_reg;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < n_channels; i++) begin
				ch_regs[i] <= '0;
			end
		end else if (tick) begin
			// New samples from the previous stage
			for (int i = 0; i < n_channels; i++) begin
				ch_regs[i] <= ch_in[i*data_width +: data_width];
			end
		end else if (result_hit) begin
			ch_regs[result.dest.addr] <= result.value;
		end
	end

	// Flattened view for the next stage
	always_comb begin
		for (int i = 0; i < n_channels; i++) begin
			ch_out[i*data_width +: data_width] = ch_regs[i];
		end
	end

	assign ch_a = ch_regs[sel_a.addr];
	assign ch_b = ch_regs[sel_b.addr];
	assign ch_c = ch_regs[sel_c.addr];

endmodule

//--- design/dsp_block.sv
module dsp_block import dsp_block_pkg::*; (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             tick,
	input  logic [n_channels*data_width-1:0] ch_in,
	output logic [n_channels*data_width-1:0] ch_out,
	input  logic                             instr_write,
	input  block_instr_t                     instr_val,
	input  reg_write_t                       reg_wr,
	output logic                             done
);

	block_instr_t  instr;
	operand_sel_t  sel_a;
	operand_sel_t  sel_b;
	operand_sel_t  sel_c;

	// Operand values from both stores
	sample_t       reg_a;
	sample_t       reg_b;
	sample_t       reg_c;
	sample_t       ch_a;
	sample_t       ch_b;
	sample_t       ch_c;

	// Arithmetic
	sample_t       adder_a;
	sample_t       adder_b;
	logic          adder_subtract;
	logic          saturate;
	sample_t       sum;
	mul_req_t      mul_req;
	sample_t       product;
	logic          product_valid;

	// Write-back goes to both stores, each takes its own side
	result_write_t result;

	block_config block_config_inst (
		.clk         (clk),
		.reset       (reset),
		.instr_write (instr_write),
		.instr_val   (instr_val),
		.reg_wr      (reg_wr),
		.result      (result),
		.sel_a       (sel_a),
		.sel_b       (sel_b),
		.sel_c       (sel_c),
		.instr       (instr),
		.reg_a       (reg_a),
		.reg_b       (reg_b),
		.reg_c       (reg_c)
	);

	channel_store channel_store_inst (
		.clk    (clk),
		.reset  (reset),
		.tick   (tick),
		.ch_in  (ch_in),
		.result (result),
		.sel_a  (sel_a),
		.sel_b  (sel_b),
		.sel_c  (sel_c),
		.ch_out (ch_out),
		.ch_a   (ch_a),
		.ch_b   (ch_b),
		.ch_c   (ch_c)
	);

	block_sequencer block_sequencer_inst (
		.clk            (clk),
		.reset          (reset),
		.tick           (tick),
		.instr          (instr),
		.reg_a          (reg_a),
		.reg_b          (reg_b),
		.reg_c          (reg_c),
		.ch_a           (ch_a),
		.ch_b           (ch_b),
		.ch_c           (ch_c),
		.sum            (sum),
		.product        (product),
		.product_valid  (product_valid),
		.sel_a          (sel_a),
		.sel_b          (sel_b),
		.sel_c          (sel_c),
		.adder_a        (adder_a),
		.adder_b        (adder_b),
		.adder_subtract (adder_subtract),
		.saturate       (saturate),
		.mul_req        (mul_req),
		.result         (result),
		.done           (done)
	);

	sat_adder sat_adder_inst (
		.clk      (clk),
		.a        (adder_a),
		.b        (adder_b),
		.subtract (adder_subtract),
		.saturate (saturate),
		.sum      (sum)
	);

	frac_multiplier frac_multiplier_inst (
		.clk           (clk),
		.reset         (reset),
		.req           (mul_req),
		.product       (product),
		.product_valid (product_valid)
	);

endmodule

//--- design/dsp_block_pkg.sv
package dsp_block_pkg;

	// Sample and storage geometry
	localparam int data_width  = 16;
	localparam int n_channels  = 16;
	localparam int n_registers = 16;
	localparam int addr_width  = 4;

	// Post-multiply shift field and multiplier depth
	localparam int shift_width = 4;
	localparam int mul_latency = 2;

	typedef logic signed [data_width-1:0] sample_t;

	// Opcodes held in the low bits of the instruction word
	typedef enum logic [4:0] {
		op_nop = 5'd0,
		op_add = 5'd1,
		op_sub = 5'd2,
		op_lsh = 5'd3,
		op_rsh = 5'd4,
		op_mul = 5'd5,
		op_mac = 5'd6,
		op_abs = 5'd7
	} block_op_e;

	// 32-bit instruction word, top bits first
	typedef struct packed {
		logic [1:0]             reserved;
		logic [shift_width-1:0] shift;
		// Set to wrap instead of clamping
		logic                   no_sat;
		logic                   dest_reg;
		logic                   src_c_reg;
		logic                   src_b_reg;
		logic                   src_a_reg;
		logic [addr_width-1:0]  dest;
		logic [addr_width-1:0]  src_c;
		logic [addr_width-1:0]  src_b;
		logic [addr_width-1:0]  src_a;
		block_op_e              op;
	} block_instr_t;

	// Host write into the coefficient file
	typedef struct packed {
		logic                  en;
		logic [addr_width-1:0] target;
		sample_t               value;
	} reg_write_t;

	// Operand address, coefficient file or channel
	typedef struct packed {
		logic                  is_reg;
		logic [addr_width-1:0] addr;
	} operand_sel_t;

	typedef struct packed {
		logic                   valid;
		sample_t                a;
		sample_t                b;
		logic [shift_width-1:0] shift;
		logic                   saturate;
	} mul_req_t;

	// Single write-back bus shared by both stores
	typedef struct packed {
		logic         en;
		operand_sel_t dest;
		sample_t      value;
	} result_write_t;

endpackage

//--- design/frac_multiplier.sv
module frac_multiplier import dsp_block_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  mul_req_t req,
	output sample_t  product,
	output logic     product_valid
);

	// Stage one registers
	logic signed [2*data_width-1:0] prod_q;
	logic [shift_width-1:0]         shift_q;
	logic                           sat_q;

	// Valid travels alongside the data with one bit per stage
	logic [mul_latency-1:0] valid_pipe;

	// Stage two combinational
	logic [shift_width-1:0]         right_shift;
	logic signed [2*data_width-1:0] shifted;
	logic                           too_high;
	logic                           too_low;

	always_ff @(posedge clk) begin
		prod_q  <= req.a * req.b;
		shift_q <= req.shift;
		sat_q   <= req.saturate;
	end

	// Q1.15 product sits 15 bits up and a nonzero shift scales it up
	assign right_shift = shift_width'(data_width - 1) - shift_q;
	assign shifted     = prod_q >>> right_shift;

	assign too_high = shifted > 32767;
	assign too_low  = shifted < -32768;

	always_ff @(posedge clk) begin
		if (sat_q && too_high) begin
			product <= {1'b0, {(data_width-1){1'b1}}};
		end else if (sat_q && too_low) begin
			product <= {1'b1, {(data_width-1){1'b0}}};
		end else begin
			// Wrap keeps the low sample bits
			product <= shifted[data_width-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[mul_latency-2:0], req.valid};
		end
	end

	assign product_valid = valid_pipe[mul_latency-1];

endmodule

//--- design/sat_adder.sv
module sat_adder import dsp_block_pkg::*; (
	input  logic    clk,
	input  sample_t a,
	input  sample_t b,
	input  logic    subtract,
	input  logic    saturate,
	output sample_t sum
);

	// One guard bit above the sample width
	logic signed [data_width:0] a_ext;
	logic signed [data_width:0] b_ext;
	logic signed [data_width:0] sum_ext;
	logic                       overflow;
	sample_t                    clamped;

	assign a_ext = {a[data_width-1], a};
	assign b_ext = {b[data_width-1], b};

	// Negating at 17 bits keeps -32768 exact
	assign sum_ext = subtract ? a_ext - b_ext : a_ext + b_ext;

	// Guard bit disagreeing with the sign means out of range
	assign overflow = sum_ext[data_width] != sum_ext[data_width-1];

	// Clamp toward the side the guard bit points to
	assign clamped = sum_ext[data_width] ? {1'b1, {(data_width-1){1'b0}}}
		: {1'b0, {(data_width-1){1'b1}}};

	always_ff @(posedge clk) begin
		if (saturate && overflow) begin
			sum <= clamped;
		end else begin
			sum <= sum_ext[data_width-1:0];
		end
	end

endmodule

//--- filelist.f
+incdir+testbench
design/dsp_block_pkg.sv
design/block_config.sv
design/channel_store.sv
design/sat_adder.sv
design/frac_multiplier.sv
design/block_sequencer.sv
design/dsp_block.sv
testbench/dsp_block_tb.sv

//--- testbench/dsp_block_vectors.svh
`ifndef dsp_block_vectors_svh
`define dsp_block_vectors_svh

// One row per tick: instruction, two optional coefficient writes, source values
// and the expected result with its done latency in edges after the tick edge
typedef struct packed {
	block_instr_t instr;
	reg_write_t   wr_first;
	reg_write_t   wr_second;
	sample_t      a_val;
	sample_t      b_val;
	sample_t      c_val;
	sample_t      expected;
	logic [3:0]   latency;
} vector_t;

vector_t vectors[$];

function automatic operand_sel_t chan(int n);
	return '{is_reg: 1'b0, addr: addr_width'(n)};
endfunction

function automatic operand_sel_t coef(int n);
	return '{is_reg: 1'b1, addr: addr_width'(n)};
endfunction

function automatic reg_write_t coef_write(int target, sample_t value);
	return '{en: 1'b1, target: addr_width'(target), value: value};
endfunction

// Saturating by default, shift zero
function automatic block_instr_t instr_of(block_op_e op, operand_sel_t dest,
		operand_sel_t a, operand_sel_t b, operand_sel_t c);
	block_instr_t word;
	word           = '0;
	word.op        = op;
	word.dest      = dest.addr;
	word.dest_reg  = dest.is_reg;
	word.src_a     = a.addr;
	word.src_a_reg = a.is_reg;
	word.src_b     = b.addr;
	word.src_b_reg = b.is_reg;
	word.src_c     = c.addr;
	word.src_c_reg = c.is_reg;
	return word;
endfunction

function automatic block_instr_t unsat(block_instr_t word);
	word.no_sat = 1'b1;
	return word;
endfunction

function automatic block_instr_t scaled(block_instr_t word, int shift);
	word.shift = shift_width'(shift);
	return word;
endfunction

task automatic add_row(block_instr_t instr, reg_write_t wr_first, reg_write_t wr_second,
		sample_t a_val, sample_t b_val, sample_t c_val, sample_t expected, int latency);
	vectors.push_back('{instr, wr_first, wr_second, a_val, b_val, c_val, expected,
		4'(latency)});
endtask

task automatic load_vectors();
	// Reset default passes the channels through
	add_row(instr_of(op_nop, chan(0), chan(0), coef(0), coef(0)), '0, '0,
		1234, 0, 0, 1234, 2);
	// Adder with channel and coefficient sources
	add_row(instr_of(op_add, chan(4), chan(2), chan(3), coef(0)), '0, '0,
		1000, 2345, 0, 3345, 3);
	add_row(instr_of(op_sub, chan(6), chan(5), coef(1), coef(0)), coef_write(1, 500), '0,
		-1200, 0, 0, -1700, 3);
	add_row(instr_of(op_add, chan(7), coef(2), coef(3), coef(0)),
		coef_write(2, 20000), coef_write(3, 20000), 0, 0, 0, 32767, 3);
	add_row(unsat(instr_of(op_add, chan(10), chan(8), chan(9), coef(0))), '0, '0,
		20000, 20000, 0, -25536, 3);
	add_row(instr_of(op_sub, chan(2), chan(0), chan(1), coef(0)), '0, '0,
		-30000, 10000, 0, -32768, 3);
	add_row(unsat(instr_of(op_sub, chan(2), chan(0), chan(1), coef(0))), '0, '0,
		-30000, 10000, 0, 25536, 3);
	add_row(instr_of(op_sub, chan(3), chan(11), chan(12), coef(0)), '0, '0,
		0, -32768, 0, 32767, 3);
	// Single-operand ops, LSH in place
	add_row(instr_of(op_lsh, chan(3), chan(3), coef(0), coef(0)), '0, '0,
		16385, 0, 0, -32766, 2);
	add_row(instr_of(op_rsh, chan(11), chan(10), coef(0), coef(0)), '0, '0,
		-7, 0, 0, -4, 2);
	add_row(instr_of(op_abs, chan(13), chan(12), coef(0), coef(0)), '0, '0,
		-1234, 0, 0, 1234, 2);
	add_row(instr_of(op_abs, chan(15), chan(15), coef(0), coef(0)), '0, '0,
		-32768, 0, 0, -32768, 2);
	// Q1.15 multiplies
	add_row(instr_of(op_mul, chan(6), chan(4), chan(5), coef(0)), '0, '0,
		16384, -16384, 0, -8192, 4);
	add_row(instr_of(op_mul, chan(8), chan(7), coef(4), coef(0)), coef_write(4, 8192), '0,
		12000, 0, 0, 3000, 4);
	add_row(scaled(instr_of(op_mul, chan(9), chan(1), chan(2), coef(0)), 2), '0, '0,
		3000, 4096, 0, 1500, 4);
	add_row(instr_of(op_mul, chan(0), chan(14), chan(15), coef(0)), '0, '0,
		-32768, -32768, 0, 32767, 4);
	add_row(unsat(instr_of(op_mul, chan(0), chan(14), chan(15), coef(0))), '0, '0,
		-32768, -32768, 0, -32768, 4);
	// Small negative product rounds toward minus infinity
	add_row(instr_of(op_mul, chan(12), chan(3), chan(11), coef(0)), '0, '0,
		-3, 5, 0, -1, 4);
	// MAC into a coefficient, r5 preset so a missing write shows
	add_row(instr_of(op_mac, coef(5), chan(0), chan(1), coef(6)),
		coef_write(6, 30000), coef_write(5, -1), 16384, 16384, 0, 32767, 5);
	add_row(instr_of(op_mac, chan(9), chan(2), chan(3), chan(4)), '0, '0,
		-16384, 16384, 1000, -7192, 5);
	add_row(unsat(instr_of(op_mac, coef(5), chan(0), chan(1), coef(6))),
		coef_write(5, 5), '0, 16384, 16384, 0, -27344, 5);
endtask

`endif

//--- testbench/dsp_block_tb.sv
module dsp_block_tb import dsp_block_pkg::*; ();

	logic                             clk;
	logic                             reset;
	logic                             tick;
	logic [n_channels*data_width-1:0] ch_in;
	logic [n_channels*data_width-1:0] ch_out;
	logic                             instr_write;
	block_instr_t                     instr_val;
	reg_write_t                       reg_wr;
	logic                             done;

	// Run limit in clock cycles from the table length
	int cycle_count;
	int cycle_limit;

	`include "dsp_block_vectors.svh"

	dsp_block dsp_block_inst (
		.clk         (clk),
		.reset       (reset),
		.tick        (tick),
		.ch_in       (ch_in),
		.ch_out      (ch_out),
		.instr_write (instr_write),
		.instr_val   (instr_val),
		.reg_wr      (reg_wr),
		.done        (done)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Done: errors found");
			$fatal(1);
		end
	end

	task automatic check_value(string name, int expected, int actual);
		if (expected != actual) begin
			$display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	// Inputs change 2 units after the rising edge
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	function automatic logic [n_channels*data_width-1:0] random_samples();
		logic [n_channels*data_width-1:0] samples;
		for (int k = 0; k < n_channels; k++) begin
			samples[k*data_width +: data_width] = data_width'($urandom);
		end
		return samples;
	endfunction

	// Counts edges from the tick edge until done is back
	task automatic run_tick(input logic [n_channels*data_width-1:0] samples, output int edges);
		ch_in = samples;
		tick  = 1'b1;
		step();
		tick = 1'b0;
		check_value("done", 0, done);
		edges = 0;
		while (!done) begin
			step();
			edges++;
		end
	endtask

	// Coefficient result copied into channel 1 by adding channel 0 held at zero
	task automatic copy_back(logic [addr_width-1:0] source, sample_t expected);
		logic [n_channels*data_width-1:0] samples;
		int                               edges;
		instr_write = 1'b1;
		instr_val   = instr_of(op_add, chan(1), coef(source), chan(0), coef(0));
		step();
		instr_write = 1'b0;
		samples     = random_samples();
		samples[data_width-1:0] = '0;
		run_tick(samples, edges);
		// The copy is an ADD and finishes on the third edge
		check_value("done rise edge", 3, edges);
		check_value("ch_out[1]", expected, $signed(ch_out[2*data_width-1:data_width]));
	endtask

	initial begin
		vector_t                          row;
		logic [n_channels*data_width-1:0] samples;
		logic [n_channels*data_width-1:0] expect_ch;
		int                               edges;
		clk         = 1'b0;
		reset       = 1'b1;
		tick        = 1'b0;
		ch_in       = '0;
		instr_write = 1'b0;
		instr_val   = '0;
		reg_wr      = '0;
		cycle_count = 0;
		void'($urandom(32'hf1aca24a));
		load_vectors();
		cycle_limit = 20 * vectors.size() + 50;

		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;
		check_value("done", 1, done);

		foreach (vectors[i]) begin
			row = vectors[i];
			// First row runs on the NOP left by reset
			if (i > 0) begin
				instr_write = 1'b1;
				instr_val   = row.instr;
			end
			reg_wr = row.wr_first;
			step();
			instr_write = 1'b0;
			reg_wr      = row.wr_second;
			step();
			reg_wr = '0;

			// Channel sources get the row values and the rest stay random
			samples = random_samples();
			if (!row.instr.src_c_reg) begin
				samples[row.instr.src_c*data_width +: data_width] = row.c_val;
			end
			if (!row.instr.src_b_reg) begin
				samples[row.instr.src_b*data_width +: data_width] = row.b_val;
			end
			if (!row.instr.src_a_reg) begin
				samples[row.instr.src_a*data_width +: data_width] = row.a_val;
			end

			// Only a channel destination changes and every other channel passes through
			expect_ch = samples;
			if (!row.instr.dest_reg) begin
				expect_ch[row.instr.dest*data_width +: data_width] = row.expected;
			end

			run_tick(samples, edges);
			check_value("done rise edge", row.latency, edges);
			for (int k = 0; k < n_channels; k++) begin
				check_value($sformatf("ch_out[%0d]", k),
					$signed(expect_ch[k*data_width +: data_width]),
					$signed(ch_out[k*data_width +: data_width]));
			end
			if (row.instr.dest_reg) begin
				copy_back(row.instr.dest, row.expected);
			end
		end

		$display("Done: no errors");
		$finish;
	end

endmodule
